// File: src/sys1_pkg.sv
// ####################################################################
// shared types and constants for the system-1 rom download path and
// the player control formatting
// compile ahead of every design file and reference by scoped name
// ####################################################################

package sys1_pkg;

	// ####################################################################
	// widths
	// ####################################################################
	localparam int DL_AW     = 25;
	localparam int MAIN_AW   = 15;
	localparam int SND_AW    = 14;
	localparam int ROM0_AW   = 14;
	localparam int SLAP_AW   = 14;
	localparam int MAIN_DW   = 16;
	localparam int SND_DW    = 8;
	localparam int NUM_BANKS = 10;

	// download stream indexes
	localparam logic [7:0] ROM_INDEX  = 8'd0;
	localparam logic [7:0] TYPE_INDEX = 8'd1;

	// ####################################################################
	// region map
	// each region has a base and the count of top address bits compared
	// ####################################################################
	localparam logic [DL_AW-1:0] ROM0_BASE  = 25'h100000;
	localparam logic [DL_AW-1:0] ROM1_BASE  = 25'h110000;
	localparam logic [DL_AW-1:0] ROM2_BASE  = 25'h120000;
	localparam logic [DL_AW-1:0] ROM5_BASE  = 25'h150000;
	localparam logic [DL_AW-1:0] ROM6_BASE  = 25'h160000;
	localparam logic [DL_AW-1:0] ROM7_BASE  = 25'h170000;
	localparam logic [DL_AW-1:0] SLAP_BASE  = 25'h180000;
	localparam logic [DL_AW-1:0] SROM0_BASE = 25'h188000;
	localparam logic [DL_AW-1:0] SROM1_BASE = 25'h18C000;
	localparam logic [DL_AW-1:0] SROM2_BASE = 25'h190000;

	// 16k words
	localparam int HALF_PW = 10;
	// 32k words
	localparam int FULL_PW = 9;
	// 16k bytes
	localparam int SND_PW  = 11;

	// ps2 scan codes, extended codes carry bit 8
	localparam logic [8:0] KEY_UP    = 9'h175;
	localparam logic [8:0] KEY_DOWN  = 9'h172;
	localparam logic [8:0] KEY_LEFT  = 9'h16B;
	localparam logic [8:0] KEY_RIGHT = 9'h174;
	localparam logic [8:0] KEY_LCTRL = 9'h014;
	localparam logic [8:0] KEY_LALT  = 9'h011;
	localparam logic [8:0] KEY_5     = 9'h02E;
	localparam logic [8:0] KEY_6     = 9'h036;
	localparam logic [8:0] KEY_7     = 9'h03D;

	// cartridge slapstic types
	typedef enum logic [7:0] {
		GAME_MARBLE   = 8'd103,
		GAME_INDY     = 8'd105,
		GAME_PETERPAK = 8'd107,
		GAME_ROADRUN  = 8'd108,
		GAME_ROADB109 = 8'd109,
		GAME_ROADB110 = 8'd110
	} game_t;

	// strobe bit positions, no rom3 bank
	typedef enum logic [3:0] {
		BANK_ROM0, BANK_ROM1, BANK_ROM2, BANK_ROM5, BANK_ROM6,
		BANK_ROM7, BANK_SLAP, BANK_SROM0, BANK_SROM1, BANK_SROM2
	} bank_e;

	// ####################################################################
	// port structs
	// ####################################################################
	typedef struct packed {
		logic             valid;
		logic [DL_AW-1:0] addr;
		logic [7:0]       index;
		logic [7:0]       data;
	} dl_byte_t;

	typedef struct packed {
		logic [MAIN_AW-1:0]   addr;
		logic [MAIN_DW-1:0]   data;
		logic [NUM_BANKS-1:0] strb;
	} rom_wr_t;

	// selects and ma18 are active low as on the board
	typedef struct packed {
		logic [4:0]         rom_n;
		logic               ma18_n;
		logic [MAIN_AW-1:0] addr;
	} main_rd_t;

	typedef struct packed {
		logic [2:0]        srom_n;
		logic [SND_AW-1:0] addr;
	} snd_rd_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} key_evt_t;

	// dir is udlr, up in bit 3
	typedef struct packed {
		logic       coin;
		logic       button2;
		logic       button1;
		logic [3:0] dir;
	} pad_t;

endpackage

// File: src/rom_bank.sv
// ####################################################################
// one cartridge rom bank
// write side filled by the loader, read side registered for the board
// ####################################################################
`timescale 1ns/1ps

module rom_bank #(
	parameter int AW = 15,
	parameter int DW = 16
) (
	input  logic          clk_sys,
	input  logic          we,
	input  logic [AW-1:0] waddr,
	input  logic [DW-1:0] wdata,
	input  logic [AW-1:0] raddr,
	output logic [DW-1:0] rdata
);

	// contents come only from the download
	logic [DW-1:0] mem [2**AW];

	// loader port
	always_ff @(posedge clk_sys)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// cpu port, one cycle of latency
	always_ff @(posedge clk_sys)
	begin
		rdata <= mem[raddr];
	end

endmodule

// File: src/rom_loader.sv
// ####################################################################
// download stream front end
// pairs rom bytes into words, decodes the bank strobe and holds the
// cartridge type loaded from index 1
// ####################################################################
`timescale 1ns/1ps

module rom_loader (
	input  logic               clk_sys,
	input  logic               rst,
	input  sys1_pkg::dl_byte_t dl,
	output sys1_pkg::rom_wr_t  wr,
	output sys1_pkg::game_t    game
);
	import sys1_pkg::*;

	logic [7:0]           prev_byte;
	logic                 rom_beat;
	logic                 odd;
	logic                 snd_hit;
	logic [NUM_BANKS-1:0] strb;

	// compare the top pw address bits against the region base
	function automatic logic in_region(
		input logic [DL_AW-1:0] a,
		input logic [DL_AW-1:0] base,
		input int               pw
	);
		return (a >> (DL_AW - pw)) == (base >> (DL_AW - pw));
	endfunction

	assign rom_beat = dl.valid && (dl.index == ROM_INDEX);
	assign odd      = dl.addr[0];

	// even byte of a word is only remembered
	always_ff @(posedge clk_sys)
	begin
		if (rst)
			prev_byte <= '0;
		else if (rom_beat)
			prev_byte <= dl.data;
	end

	// ####################################################################
	// region decode
	// ####################################################################
	always_comb
	begin
		strb = '0;
		if (rom_beat)
		begin
			// word regions fire on the odd byte
			strb[BANK_ROM0]  = odd && in_region(dl.addr, ROM0_BASE, HALF_PW);
			strb[BANK_ROM1]  = odd && in_region(dl.addr, ROM1_BASE, FULL_PW);
			strb[BANK_ROM2]  = odd && in_region(dl.addr, ROM2_BASE, FULL_PW);
			strb[BANK_ROM5]  = odd && in_region(dl.addr, ROM5_BASE, FULL_PW);
			strb[BANK_ROM6]  = odd && in_region(dl.addr, ROM6_BASE, FULL_PW);
			strb[BANK_ROM7]  = odd && in_region(dl.addr, ROM7_BASE, FULL_PW);
			strb[BANK_SLAP]  = odd && in_region(dl.addr, SLAP_BASE, HALF_PW);
			// byte regions take every beat
			strb[BANK_SROM0] = in_region(dl.addr, SROM0_BASE, SND_PW);
			strb[BANK_SROM1] = in_region(dl.addr, SROM1_BASE, SND_PW);
			strb[BANK_SROM2] = in_region(dl.addr, SROM2_BASE, SND_PW);
		end
	end

	assign snd_hit = strb[BANK_SROM0] | strb[BANK_SROM1] | strb[BANK_SROM2];

	// sound banks see the byte address, main banks the word address
	assign wr = '{
		addr: snd_hit ? MAIN_AW'(dl.addr[SND_AW-1:0]) : dl.addr[MAIN_AW:1],
		data: snd_hit ? MAIN_DW'(dl.data) : {prev_byte, dl.data},
		strb: strb
	};

	// cartridge type, visible the cycle after the beat
	always_ff @(posedge clk_sys)
	begin
		if (rst)
			game <= GAME_INDY;
		else if (dl.valid && (dl.index == TYPE_INDEX))
			game <= game_t'(dl.data);
	end

endmodule

// File: src/cart_rom_mux.sv
// ####################################################################
// cartridge rom banks with the main and sound read muxes
// selects are registered next to the bank read so data lines up
// rom3 has no bank and is served from rom7
// ####################################################################
`timescale 1ns/1ps

module cart_rom_mux (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  sys1_pkg::rom_wr_t            wr,
	input  sys1_pkg::main_rd_t           main_rd,
	input  sys1_pkg::snd_rd_t            snd_rd,
	output logic [sys1_pkg::MAIN_DW-1:0] main_data,
	output logic [sys1_pkg::SND_DW-1:0]  snd_data
);
	import sys1_pkg::*;

	logic [MAIN_DW-1:0] rom0_q;
	logic [MAIN_DW-1:0] slap_q;
	// rom1 rom2 rom5 rom6 rom7 in that order
	logic [MAIN_DW-1:0] big_q [5];
	logic [SND_DW-1:0]  snd_q [3];
	logic [4:0]         sel_q;
	logic               ma18_n_q;
	logic [2:0]         ssel_q;

	// ####################################################################
	// banks
	// ####################################################################
	rom_bank #(.AW(ROM0_AW), .DW(MAIN_DW)) u_rom0 (
		.clk_sys (clk_sys),
		.we      (wr.strb[BANK_ROM0]),
		.waddr   (wr.addr[ROM0_AW-1:0]),
		.wdata   (wr.data),
		.raddr   (main_rd.addr[ROM0_AW-1:0]),
		.rdata   (rom0_q)
	);

	rom_bank #(.AW(SLAP_AW), .DW(MAIN_DW)) u_slap (
		.clk_sys (clk_sys),
		.we      (wr.strb[BANK_SLAP]),
		.waddr   (wr.addr[SLAP_AW-1:0]),
		.wdata   (wr.data),
		.raddr   (main_rd.addr[SLAP_AW-1:0]),
		.rdata   (slap_q)
	);

	// full size banks sit on consecutive strobe bits
	for (genvar i = 0; i < 5; i++)
	begin : g_main
		rom_bank #(.AW(MAIN_AW), .DW(MAIN_DW)) u_bank (
			.clk_sys (clk_sys),
			.we      (wr.strb[int'(BANK_ROM1) + i]),
			.waddr   (wr.addr),
			.wdata   (wr.data),
			.raddr   (main_rd.addr),
			.rdata   (big_q[i])
		);
	end

	for (genvar i = 0; i < 3; i++)
	begin : g_snd
		rom_bank #(.AW(SND_AW), .DW(SND_DW)) u_bank (
			.clk_sys (clk_sys),
			.we      (wr.strb[int'(BANK_SROM0) + i]),
			.waddr   (wr.addr[SND_AW-1:0]),
			.wdata   (wr.data[SND_DW-1:0]),
			.raddr   (snd_rd.addr),
			.rdata   (snd_q[i])
		);
	end

	// selects flipped to active high, cleared selects read as zero
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			sel_q    <= '0;
			ma18_n_q <= 1'b0;
			ssel_q   <= '0;
		end
		else
		begin
			sel_q    <= ~main_rd.rom_n;
			ma18_n_q <= main_rd.ma18_n;
			ssel_q   <= ~snd_rd.srom_n;
		end
	end

	// ####################################################################
	// read muxes, first match wins
	// ####################################################################
	always_comb
	begin
		if (sel_q[0] && ma18_n_q)
			main_data = rom0_q;
		else if (sel_q[1] && ma18_n_q)
			main_data = big_q[0];
		else if (sel_q[2] && ma18_n_q)
			main_data = big_q[1];
		// rom3 remapped into rom7
		else if (sel_q[3] && ma18_n_q)
			main_data = big_q[4];
		else if (sel_q[1] && !ma18_n_q)
			main_data = big_q[2];
		else if (sel_q[2] && !ma18_n_q)
			main_data = big_q[3];
		else if (sel_q[3] && !ma18_n_q)
			main_data = big_q[4];
		else if (sel_q[4])
			main_data = slap_q;
		else
			main_data = '0;
	end

	always_comb
	begin
		if (ssel_q[0])
			snd_data = snd_q[0];
		else if (ssel_q[1])
			snd_data = snd_q[1];
		else if (ssel_q[2])
			snd_data = snd_q[2];
		else
			snd_data = '0;
	end

endmodule

// File: src/control_mapper.sv
// ####################################################################
// player control formatting
// keyboard events are held as key bits and merged with pad1 into the
// joystick, switch and coin bytes, laid out per cartridge type
// ####################################################################
`timescale 1ns/1ps

module control_mapper (
	input  logic               clk_sys,
	input  logic               rst,
	input  sys1_pkg::key_evt_t key,
	input  sys1_pkg::pad_t     pad1,
	input  sys1_pkg::game_t    game,
	output logic [7:0]         joy,
	output logic [7:0]         switches,
	output logic [2:0]         coin_n
);
	import sys1_pkg::*;

	logic       tog_q;
	// udlr, up in bit 3
	logic [3:0] kbd_dir;
	logic       kbd_start;
	logic       kbd_jump;
	logic       coin_l;
	logic       coin_r;
	logic       coin_aux;
	logic [3:0] dir;
	logic       jump;
	logic       start;

	// ####################################################################
	// key event capture
	// ####################################################################
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			tog_q     <= 1'b0;
			kbd_dir   <= '0;
			kbd_start <= 1'b0;
			kbd_jump  <= 1'b0;
			coin_l    <= 1'b0;
			coin_r    <= 1'b0;
			coin_aux  <= 1'b0;
		end
		else
		begin
			tog_q <= key.toggle;
			// new event only when the toggle flips
			if (key.toggle != tog_q)
			begin
				case (key.code)
					KEY_UP:    kbd_dir[3] <= key.pressed;
					KEY_DOWN:  kbd_dir[2] <= key.pressed;
					KEY_LEFT:  kbd_dir[1] <= key.pressed;
					KEY_RIGHT: kbd_dir[0] <= key.pressed;
					// start doubles as whip
					KEY_LCTRL: kbd_start  <= key.pressed;
					KEY_LALT:  kbd_jump   <= key.pressed;
					KEY_5:     coin_l     <= key.pressed;
					KEY_6:     coin_r     <= key.pressed;
					KEY_7:     coin_aux   <= key.pressed;
					default:   ;
				endcase
			end
		end
	end

	// keyboard and pad merged
	assign dir   = kbd_dir | pad1.dir;
	assign jump  = kbd_jump | pad1.button1;
	assign start = kbd_start | pad1.button2;

	// ####################################################################
	// board bytes
	// ####################################################################
	always_comb
	begin
		// indy reads the stick one bit up
		if (game == GAME_INDY)
			joy = {3'b000, dir, 1'b0};
		else
			joy = {4'b0000, dir};
	end

	// sw5 down to sw1 in bits 4:0, active low
	always_comb
	begin
		if (game == GAME_PETERPAK)
			switches = {3'b000, 2'b11, ~jump, 1'b1, ~start};
		else
			switches = {3'b000, 3'b111, ~jump, ~start};
	end

	// aux, right, left
	assign coin_n = {~coin_aux, ~coin_r, ~(coin_l | pad1.coin)};

endmodule

// File: src/sys1_rom_io.sv
// ####################################################################
// top of the system-1 rom and control glue
// download stream in, cartridge reads and player bytes out
// ####################################################################
`timescale 1ns/1ps

module sys1_rom_io (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  sys1_pkg::dl_byte_t           dl,
	input  sys1_pkg::main_rd_t           main_rd,
	input  sys1_pkg::snd_rd_t            snd_rd,
	input  sys1_pkg::key_evt_t           key,
	input  sys1_pkg::pad_t               pad1,
	output logic [sys1_pkg::MAIN_DW-1:0] main_data,
	output logic [sys1_pkg::SND_DW-1:0]  snd_data,
	output sys1_pkg::game_t              game,
	output logic [7:0]                   joy,
	output logic [7:0]                   switches,
	output logic [2:0]                   coin_n
);
	import sys1_pkg::*;

	// loader to banks
	rom_wr_t wr;

	rom_loader u_loader (
		.clk_sys (clk_sys),
		.rst     (rst),
		.dl      (dl),
		.wr      (wr),
		.game    (game)
	);

	cart_rom_mux u_cart (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.wr        (wr),
		.main_rd   (main_rd),
		.snd_rd    (snd_rd),
		.main_data (main_data),
		.snd_data  (snd_data)
	);

	// type register also steers the control layout
	control_mapper u_ctrl (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.key      (key),
		.pad1     (pad1),
		.game     (game),
		.joy      (joy),
		.switches (switches),
		.coin_n   (coin_n)
	);

endmodule

// File: verif/sys1_rom_io_asserts.sv
// ####################################################################
// concurrent checks on the rom loader and the cartridge read muxes
// bound twice, once per side, LOADER_SIDE picks the active group
// ####################################################################
`timescale 1ns/1ps

module sys1_rom_io_asserts #(
	parameter bit LOADER_SIDE = 1'b1
) (
	input logic                         clk_sys,
	input logic                         rst,
	input sys1_pkg::rom_wr_t            wr,
	input sys1_pkg::dl_byte_t           dl,
	input sys1_pkg::game_t              game,
	input sys1_pkg::main_rd_t           main_rd,
	input sys1_pkg::snd_rd_t            snd_rd,
	input logic [sys1_pkg::MAIN_DW-1:0] main_data,
	input logic [sys1_pkg::SND_DW-1:0]  snd_data
);
	import sys1_pkg::*;

	// never two banks written by one beat
	a_strb_onehot: assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0(wr.strb))
		else $error("bank strobe not one-hot: %b", wr.strb);

	// word banks take the pair on the odd byte only
	a_main_odd: assert property (@(posedge clk_sys) disable iff (rst)
		(LOADER_SIDE && (|wr.strb[int'(BANK_SLAP):0])) |-> dl.addr[0])
		else $error("main bank written on an even address");

	// type register only moves after an index 1 beat
	a_game_src: assert property (@(posedge clk_sys) disable iff (rst)
		(LOADER_SIDE && !$stable(game)) |->
			$past(dl.valid && (dl.index == TYPE_INDEX)))
		else $error("game type changed without a type download");

	// a request with no select reads back as zero one cycle later
	a_main_idle: assert property (@(posedge clk_sys) disable iff (rst)
		(!LOADER_SIDE && (main_rd.rom_n == '1)) |=> (main_data == '0))
		else $error("main data nonzero after a read with no select");

	a_snd_idle: assert property (@(posedge clk_sys) disable iff (rst)
		(!LOADER_SIDE && (snd_rd.srom_n == '1)) |=> (snd_data == '0))
		else $error("sound data nonzero after a read with no select");

endmodule

bind rom_loader sys1_rom_io_asserts #(.LOADER_SIDE(1'b1)) u_ld_chk (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.wr        (wr),
	.dl        (dl),
	.game      (game),
	.main_rd   ('0),
	.snd_rd    ('0),
	.main_data (16'h0),
	.snd_data  (8'h0)
);

bind cart_rom_mux sys1_rom_io_asserts #(.LOADER_SIDE(1'b0)) u_rd_chk (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.wr        (wr),
	.dl        ('0),
	.game      (sys1_pkg::GAME_INDY),
	.main_rd   (main_rd),
	.snd_rd    (snd_rd),
	.main_data (main_data),
	.snd_data  (snd_data)
);

// File: verif/tb_sys1_rom_io.sv
// ####################################################################
// testbench for the system-1 rom and control glue
// replays the command file under verif/ against the DUT and checks
// read data, game type and control bytes, then prints a summary
// ####################################################################
`timescale 1ns/1ps

module tb_sys1_rom_io;
	import sys1_pkg::*;

	logic               clk_sys;
	logic               rst;
	dl_byte_t           dl;
	main_rd_t           main_rd;
	snd_rd_t            snd_rd;
	key_evt_t           key;
	pad_t               pad1;
	logic [MAIN_DW-1:0] main_data;
	logic [SND_DW-1:0]  snd_data;
	game_t              game;
	logic [7:0]         joy;
	logic [7:0]         switches;
	logic [2:0]         coin_n;

	// parsed commands
	string            ops [$];
	string            names [$];
	logic [3:0][31:0] args [$];

	int    errors;
	int    checks;
	int    tests;
	int    test_errs;
	bit    test_open;
	string cur_name;

	sys1_rom_io dut (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl        (dl),
		.main_rd   (main_rd),
		.snd_rd    (snd_rd),
		.key       (key),
		.pad1      (pad1),
		.main_data (main_data),
		.snd_data  (snd_data),
		.game      (game),
		.joy       (joy),
		.switches  (switches),
		.coin_n    (coin_n)
	);

	// 40 ns period
	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// inputs change 2 ns past the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// ####################################################################
	// compare tasks
	// ####################################################################
	task automatic check_main(input logic [MAIN_DW-1:0] exp, input logic [MAIN_DW-1:0] got);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED t=%0t main_data expected %h got %h", $time, exp, got);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_snd(input logic [SND_DW-1:0] exp, input logic [SND_DW-1:0] got);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED t=%0t snd_data expected %h got %h", $time, exp, got);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_game(input game_t exp, input game_t got);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED t=%0t game expected %0d got %0d", $time, exp, got);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_ctrl(input logic [7:0] exp_joy, input logic [7:0] exp_sw,
		input logic [2:0] exp_coin);
		checks++;
		if (joy !== exp_joy)
			$display("FAILED t=%0t joy expected %h got %h", $time, exp_joy, joy);
		if (switches !== exp_sw)
			$display("FAILED t=%0t switches expected %h got %h", $time, exp_sw, switches);
		if (coin_n !== exp_coin)
			$display("FAILED t=%0t coin_n expected %b got %b", $time, exp_coin, coin_n);
		if ((joy !== exp_joy) || (switches !== exp_sw) || (coin_n !== exp_coin))
		begin
			errors++;
			test_errs++;
		end
	endtask

	// ####################################################################
	// command file
	// ####################################################################
	task automatic load_stimulus(input int fd);
		string       op;
		string       name;
		string       rest;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		int          n;
		int          want;
		while ($fscanf(fd, "%s", op) == 1)
		begin
			a0 = '0;
			a1 = '0;
			a2 = '0;
			a3 = '0;
			name = "";
			n = 0;
			want = 3;
			if (op[0] == "#")
				void'($fgets(rest, fd));
			else
			begin
				case (op)
					"test":
					begin
						want = 1;
						n = $fscanf(fd, "%s", name);
					end
					"game":
					begin
						want = 1;
						n = $fscanf(fd, "%d", a0);
					end
					"dl", "snd", "key", "ctrl": n = $fscanf(fd, "%h %h %h", a0, a1, a2);
					"main", "pad":
					begin
						want = 4;
						n = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
					end
					default: want = -1;
				endcase
				if (want < 0 || n != want)
				begin
					$display("stimulus file: unknown or incomplete command '%s'", op);
					errors++;
				end
				else
				begin
					ops.push_back(op);
					names.push_back(name);
					args.push_back({a3, a2, a1, a0});
				end
			end
		end
	endtask

	task automatic close_test();
		if (test_open)
		begin
			$display("test %s: %s", cur_name, (test_errs == 0) ? "ok" : "mismatch");
			tests++;
		end
		test_open = 1'b0;
	endtask

	task automatic run_command(input string op, input string name, input logic [3:0][31:0] v);
		case (op)
			"test":
			begin
				close_test();
				cur_name = name;
				test_errs = 0;
				test_open = 1'b1;
			end
			"dl":
			begin
				dl.valid = 1'b1;
				dl.index = v[0][7:0];
				dl.addr = v[1][DL_AW-1:0];
				dl.data = v[2][7:0];
				next_cycle();
				dl.valid = 1'b0;
			end
			"main":
			begin
				main_rd.rom_n = v[0][4:0];
				main_rd.ma18_n = v[1][0];
				main_rd.addr = v[2][MAIN_AW-1:0];
				next_cycle();
				check_main(v[3][MAIN_DW-1:0], main_data);
				main_rd.rom_n = 5'h1f;
			end
			"snd":
			begin
				snd_rd.srom_n = v[0][2:0];
				snd_rd.addr = v[1][SND_AW-1:0];
				next_cycle();
				check_snd(v[2][SND_DW-1:0], snd_data);
				snd_rd.srom_n = 3'h7;
			end
			"key":
			begin
				key.toggle = v[0][0];
				key.pressed = v[1][0];
				key.code = v[2][8:0];
				next_cycle();
			end
			"pad":
			begin
				pad1.coin = v[0][0];
				pad1.button2 = v[1][0];
				pad1.button1 = v[2][0];
				pad1.dir = v[3][3:0];
			end
			"game":
			begin
				next_cycle();
				check_game(game_t'(v[0][7:0]), game);
			end
			default:
			begin
				next_cycle();
				check_ctrl(v[0][7:0], v[1][7:0], v[2][2:0]);
			end
		endcase
	endtask

	initial
	begin
		int fd;
		int wd_ns;
		rst = 1'b1;
		dl = '0;
		main_rd = '0;
		main_rd.rom_n = 5'h1f;
		main_rd.ma18_n = 1'b1;
		snd_rd = '0;
		snd_rd.srom_n = 3'h7;
		key = '0;
		pad1 = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errs = 0;
		test_open = 1'b0;
		fd = $fopen("verif/sys1_rom_io_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file verif/sys1_rom_io_stimulus.txt");
			$display("Simulation failed");
			$finish;
		end
		else
		begin
			load_stimulus(fd);
			$fclose(fd);
			// four clock periods per command plus reset
			wd_ns = (ops.size() + 4) * 4 * 40;
			fork
				begin
					#(wd_ns);
					$display("watchdog expired after %0d ns, commands did not finish", wd_ns);
					$display("Simulation failed");
					$finish;
				end
			join_none
			repeat (3) @(posedge clk_sys);
			#2;
			rst = 1'b0;
			for (int i = 0; i < ops.size(); i++)
				run_command(ops[i], names[i], args[i]);
			close_test();
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: sys1_rom_io.f
src/sys1_pkg.sv
src/rom_bank.sv
src/rom_loader.sv
src/cart_rom_mux.sv
src/control_mapper.sv
src/sys1_rom_io.sv
verif/sys1_rom_io_asserts.sv
verif/tb_sys1_rom_io.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sys1_rom_io
FILELIST  = sys1_rom_io.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
PASS_MSG  = Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/sys1_rom_io_stimulus.txt
# test name | dl index addr data | main rom_n ma18_n addr expect | snd srom_n addr expect
# key toggle pressed code | pad coin b2 b1 dir | game expect(dec) | ctrl joy sw coin_n
test reset
game 105
ctrl 00 1f 7
main 1f 1 0000 0000
snd 7 0000 00
test rom_words
dl 0 100004 12
dl 0 100005 34
dl 0 110004 ab
dl 0 110005 cd
dl 0 120020 56
dl 0 120021 78
dl 0 150004 9a
dl 0 150005 bc
dl 0 160040 de
dl 0 160041 f0
dl 0 180006 0f
dl 0 180007 1e
dl 0 170100 77
dl 0 170101 88
main 1e 1 0002 1234
main 1d 1 0002 abcd
main 1b 1 0010 5678
main 1d 0 0002 9abc
main 1b 0 0020 def0
main 0f 1 0003 0f1e
test remap
main 17 1 0080 7788
main 17 0 0080 7788
main 1c 1 0002 1234
main 1e 0 0002 0000
main 1f 1 0002 0000
test sound
dl 0 188005 5a
dl 0 18c005 a5
dl 0 190007 3c
snd 6 0005 5a
snd 5 0005 a5
snd 3 0007 3c
snd 4 0005 5a
snd 7 0005 00
test ctrl_indy
key 1 1 175
ctrl 10 1f 7
key 0 1 014
ctrl 10 1e 7
key 0 1 011
ctrl 10 1e 7
key 1 1 02e
ctrl 10 1e 6
pad 0 0 1 1
ctrl 12 1c 6
key 0 0 02e
ctrl 12 1c 7
test game_type
dl 1 100005 6b
game 107
main 1e 1 0002 1234
test ctrl_peterpak
ctrl 09 1a 7
pad 1 1 0 4
ctrl 0c 1e 6
key 1 0 175
ctrl 04 1e 6
